// File: verilog/i3c_target_pkg.sv
// ********************
// Shared types of the I3C target engine
// State enum, byte and address types, broadcast byte
// ********************
package i3c_target_pkg;

  // One byte as it is seen on the bus
  typedef logic [7:0] byte_t;

  // 7-bit target address
  typedef logic [6:0] addr_t;

  // Primary transfer states
  typedef enum logic [3:0] {
    Idle,
    RxAddr,
    CheckAddr,
    TxAck,
    RxRsvdNext,
    RxWriteData,
    RxWriteTbit,
    TxReadData,
    TxReadTbit,
    Wait
  } target_state_e;

  // Broadcast address 7E with the write bit
  localparam byte_t RsvdByte = 8'hFC;

endpackage

// File: verilog/i3c_target_if.sv
// ********************
// Interfaces between the target FSM and its helpers
// addr_if to the address decoder, tx_if to the TX datapath
// ********************
`timescale 1ns/1ns

interface addr_if;
  // Driven by the FSM
  logic                  capture;
  i3c_target_pkg::byte_t rx_byte;
  logic                  idle;

  // Driven by the decoder, valid from the cycle after capture
  logic                  match;
  logic                  rnw;
  logic                  rsvd;

  modport fsm (
    output capture, rx_byte, idle,
    input  match, rnw, rsvd
  );

  modport decoder (
    input  capture, rx_byte, idle,
    output match, rnw, rsvd
  );
endinterface

interface tx_if;
  // Pop strobe and T-bit completion from the FSM
  logic                  load;
  logic                  tbit_sent;

  // Byte to send and continue flag from the datapath
  i3c_target_pkg::byte_t data;
  logic                  more;

  modport fsm (
    output load, tbit_sent,
    input  data, more
  );

  modport datapath (
    input  load, tbit_sent,
    output data, more
  );
endinterface

// File: verilog/i3c_addr_decoder.sv
// ********************
// Address byte capture and match
// ********************
`timescale 1ns/1ns

module i3c_addr_decoder (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  addr_if.decoder               addr,
  input  i3c_target_pkg::addr_t target_sta_address_i,
  input  logic                  target_sta_address_valid_i,
  input  i3c_target_pkg::addr_t target_dyn_address_i,
  input  logic                  target_dyn_address_valid_i,
  input  logic                  bus_start_det_i,
  output i3c_target_pkg::byte_t last_addr_o,
  output logic                  last_addr_valid_o
);
  i3c_target_pkg::addr_t cap_addr;
  logic                  cap_match;
  i3c_target_pkg::byte_t addr_byte_q;
  logic                  match_q;
  logic                  rsvd_q;

  assign cap_addr = addr.rx_byte[7:1];

  // Dynamic address wins over static, none valid means no match
  always_comb begin
    if (target_dyn_address_valid_i) begin
      cap_match = (cap_addr == target_dyn_address_i);
    end else if (target_sta_address_valid_i) begin
      cap_match = (cap_addr == target_sta_address_i);
    end else begin
      cap_match = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_byte_q <= '0;
      match_q     <= 1'b0;
      rsvd_q      <= 1'b0;
    end else if (addr.capture) begin
      addr_byte_q <= addr.rx_byte;
      match_q     <= cap_match;
      rsvd_q      <= (addr.rx_byte == i3c_target_pkg::RsvdByte);
    end else if (addr.idle) begin
      addr_byte_q <= '0;
      match_q     <= 1'b0;
      rsvd_q      <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_addr_valid_o <= 1'b0;
    end else if (bus_start_det_i) begin
      last_addr_valid_o <= 1'b0;
    end else if (addr.capture) begin
      last_addr_valid_o <= 1'b1;
    end
  end

  assign addr.match  = match_q;
  assign addr.rnw    = addr_byte_q[0];
  assign addr.rsvd   = rsvd_q;
  assign last_addr_o = addr_byte_q;

endmodule

// File: verilog/i3c_target_fsm.sv
// ********************
// Primary transfer FSM of the I3C target
// Address phase, private write and private read
// ********************
`timescale 1ns/1ns

module i3c_target_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  bus_start_det_i,
  input  logic                  bus_rstart_det_i,
  input  logic                  bus_stop_det_i,
  output logic                  bus_rx_req_byte_o,
  output logic                  bus_rx_req_bit_o,
  input  logic                  bus_rx_done_i,
  input  i3c_target_pkg::byte_t bus_rx_data_i,
  output logic                  bus_tx_req_byte_o,
  output logic                  bus_tx_req_bit_o,
  output i3c_target_pkg::byte_t bus_tx_req_value_o,
  input  logic                  bus_tx_done_i,
  input  logic                  tx_desc_avail_i,
  addr_if.fsm                   addr,
  tx_if.fsm                     tx,
  output logic                  rx_byte_done_o,
  output logic                  rx_tbit_done_o,
  output logic                  target_idle_o,
  output logic                  target_transmitting_o,
  output logic                  event_target_nack_o
);
  i3c_target_pkg::target_state_e state_q;
  i3c_target_pkg::target_state_e state_d;
  logic                          start;
  logic                          load_q;

  // START and repeated START are handled alike
  assign start = bus_start_det_i | bus_rstart_det_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      i3c_target_pkg::RxAddr: begin
        if (bus_rx_done_i) state_d = i3c_target_pkg::CheckAddr;
      end
      i3c_target_pkg::CheckAddr: begin
        // Reads are only ACKed with a descriptor ready
        if (addr.rsvd || (addr.match && (!addr.rnw || tx_desc_avail_i))) begin
          state_d = i3c_target_pkg::TxAck;
        end else begin
          state_d = i3c_target_pkg::Wait;
        end
      end
      i3c_target_pkg::TxAck: begin
        if (bus_tx_done_i) begin
          if (addr.rsvd) state_d = i3c_target_pkg::RxRsvdNext;
          else if (addr.rnw) state_d = i3c_target_pkg::TxReadData;
          else state_d = i3c_target_pkg::RxWriteData;
        end
      end
      // A data byte here is a CCC, which is not handled
      i3c_target_pkg::RxRsvdNext: begin
        if (bus_rx_done_i) state_d = i3c_target_pkg::Wait;
      end
      i3c_target_pkg::RxWriteData: begin
        if (bus_rx_done_i) state_d = i3c_target_pkg::RxWriteTbit;
      end
      i3c_target_pkg::RxWriteTbit: begin
        if (bus_rx_done_i) state_d = i3c_target_pkg::RxWriteData;
      end
      i3c_target_pkg::TxReadData: begin
        if (bus_tx_done_i) state_d = i3c_target_pkg::TxReadTbit;
      end
      i3c_target_pkg::TxReadTbit: begin
        if (bus_tx_done_i) begin
          if (tx.more) state_d = i3c_target_pkg::TxReadData;
          else state_d = i3c_target_pkg::Wait;
        end
      end
      default: ;
    endcase
    // Bus conditions override everything, STOP last
    if (start) state_d = i3c_target_pkg::RxAddr;
    if (bus_stop_det_i) state_d = i3c_target_pkg::Idle;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= i3c_target_pkg::Idle;
      load_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Marks the first cycle of each read byte
      load_q  <= (state_d == i3c_target_pkg::TxReadData) &&
                 (state_q != i3c_target_pkg::TxReadData);
    end
  end

  // Bus requests
  always_comb begin
    bus_rx_req_byte_o  = 1'b0;
    bus_rx_req_bit_o   = 1'b0;
    bus_tx_req_byte_o  = 1'b0;
    bus_tx_req_bit_o   = 1'b0;
    bus_tx_req_value_o = 8'h01;
    case (state_q)
      i3c_target_pkg::RxAddr,
      i3c_target_pkg::RxRsvdNext,
      i3c_target_pkg::RxWriteData: bus_rx_req_byte_o = ~start;
      i3c_target_pkg::RxWriteTbit: bus_rx_req_bit_o = ~start;
      i3c_target_pkg::TxAck: begin
        bus_tx_req_bit_o   = ~start;
        bus_tx_req_value_o = 8'h00;
      end
      i3c_target_pkg::TxReadData: begin
        bus_tx_req_byte_o  = ~start;
        bus_tx_req_value_o = tx.data;
      end
      // T-bit of 1 announces another byte
      i3c_target_pkg::TxReadTbit: begin
        bus_tx_req_bit_o   = ~start;
        bus_tx_req_value_o = {7'b0, tx.more};
      end
      default: ;
    endcase
  end

  assign addr.capture = (state_q == i3c_target_pkg::RxAddr) & bus_rx_done_i & ~start;
  assign addr.rx_byte = bus_rx_data_i;
  assign addr.idle    = target_idle_o;

  assign tx.load      = load_q;
  assign tx.tbit_sent = (state_q == i3c_target_pkg::TxReadTbit) & bus_tx_done_i & ~start;

  assign rx_byte_done_o = (state_q == i3c_target_pkg::RxWriteData) & bus_rx_done_i & ~start;
  assign rx_tbit_done_o = (state_q == i3c_target_pkg::RxWriteTbit) & bus_rx_done_i & ~start;

  assign target_idle_o         = (state_q == i3c_target_pkg::Idle);
  assign target_transmitting_o = (state_q == i3c_target_pkg::TxAck) ||
                                 (state_q == i3c_target_pkg::TxReadData) ||
                                 (state_q == i3c_target_pkg::TxReadTbit);
  assign event_target_nack_o   = (state_d == i3c_target_pkg::Wait) &&
                                 (state_q != i3c_target_pkg::Wait);

endmodule

// File: verilog/i3c_rx_datapath.sv
// ********************
// Private write datapath
// Parity check and RX FIFO push with overflow detection
// ********************
`timescale 1ns/1ns

module i3c_rx_datapath (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rx_byte_done_i,
  input  logic                  rx_tbit_done_i,
  input  i3c_target_pkg::byte_t bus_rx_data_i,
  input  logic                  rx_fifo_wready_i,
  output logic                  rx_fifo_wvalid_o,
  output i3c_target_pkg::byte_t rx_fifo_wdata_o,
  output logic                  parity_err_o,
  output logic                  rx_overflow_err_o
);
  i3c_target_pkg::byte_t data_q;
  logic                  parity_ok;
  logic                  good_byte;
  logic                  waiting;

  // Odd parity, T-bit is the inverted XOR of the data
  assign parity_ok = (bus_rx_data_i[0] == ~^data_q);
  assign good_byte = rx_tbit_done_i & parity_ok;
  assign waiting   = rx_fifo_wvalid_o & ~rx_fifo_wready_i;

  always_ff @(posedge clk_i) begin
    if (rx_byte_done_i) data_q <= bus_rx_data_i;
  end

  // Held stable for the FIFO until accepted
  always_ff @(posedge clk_i) begin
    if (good_byte && !waiting) rx_fifo_wdata_o <= data_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_fifo_wvalid_o  <= 1'b0;
      parity_err_o      <= 1'b0;
      rx_overflow_err_o <= 1'b0;
    end else begin
      if (good_byte && !waiting) begin
        rx_fifo_wvalid_o <= 1'b1;
      end else if (rx_fifo_wready_i) begin
        rx_fifo_wvalid_o <= 1'b0;
      end
      parity_err_o      <= rx_tbit_done_i & ~parity_ok;
      // New byte lost behind a stalled one
      rx_overflow_err_o <= good_byte & waiting;
    end
  end

endmodule

// File: verilog/i3c_tx_datapath.sv
// ********************
// Private read datapath
// TX FIFO pop, byte hold, continue flag
// ********************
`timescale 1ns/1ns

module i3c_tx_datapath (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  tx_if.datapath                tx,
  input  i3c_target_pkg::byte_t tx_fifo_rdata_i,
  input  logic                  tx_last_byte_i,
  input  logic                  tx_fifo_rvalid_i,
  output logic                  tx_fifo_rready_o
);
  i3c_target_pkg::byte_t data_q;
  logic                  last_q;
  logic                  ended_q;

  assign tx_fifo_rready_o = tx.load;

  // Show-ahead head is already valid in the pop cycle
  assign tx.data = tx.load ? tx_fifo_rdata_i : data_q;

  // Another byte follows unless the held one was the last
  assign tx.more = (tx_fifo_rvalid_i | tx_last_byte_i) & ~last_q & ~ended_q;

  always_ff @(posedge clk_i) begin
    if (tx.load) data_q <= tx_fifo_rdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q  <= 1'b0;
      ended_q <= 1'b0;
    end else if (tx.load) begin
      last_q  <= tx_last_byte_i;
      ended_q <= 1'b0;
    end else if (tx.tbit_sent && !tx.more) begin
      // Transfer closed, keep more low until the next pop
      ended_q <= 1'b1;
    end
  end

endmodule

// File: verilog/i3c_target.sv
// ********************
// Top level of the I3C target engine
// ********************
`timescale 1ns/1ns

module i3c_target (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  bus_start_det_i,
  input  logic                  bus_rstart_det_i,
  input  logic                  bus_stop_det_i,
  input  logic                  bus_rx_done_i,
  input  i3c_target_pkg::byte_t bus_rx_data_i,
  input  logic                  bus_tx_done_i,
  input  i3c_target_pkg::addr_t target_sta_address_i,
  input  logic                  target_sta_address_valid_i,
  input  i3c_target_pkg::addr_t target_dyn_address_i,
  input  logic                  target_dyn_address_valid_i,
  input  logic                  tx_desc_avail_i,
  input  logic                  tx_fifo_rvalid_i,
  input  i3c_target_pkg::byte_t tx_fifo_rdata_i,
  input  logic                  tx_last_byte_i,
  input  logic                  rx_fifo_wready_i,
  output logic                  bus_rx_req_byte_o,
  output logic                  bus_rx_req_bit_o,
  output logic                  bus_tx_req_byte_o,
  output logic                  bus_tx_req_bit_o,
  output i3c_target_pkg::byte_t bus_tx_req_value_o,
  output logic                  tx_fifo_rready_o,
  output logic                  rx_fifo_wvalid_o,
  output i3c_target_pkg::byte_t rx_fifo_wdata_o,
  output logic                  target_idle_o,
  output logic                  target_transmitting_o,
  output logic                  event_target_nack_o,
  output i3c_target_pkg::byte_t last_addr_o,
  output logic                  last_addr_valid_o,
  output logic                  parity_err_o,
  output logic                  rx_overflow_err_o
);
  logic rx_byte_done;
  logic rx_tbit_done;

  addr_if u_addr_if ();
  tx_if   u_tx_if ();

  i3c_addr_decoder u_addr_decoder (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .addr                       (u_addr_if.decoder),
    .target_sta_address_i       (target_sta_address_i),
    .target_sta_address_valid_i (target_sta_address_valid_i),
    .target_dyn_address_i       (target_dyn_address_i),
    .target_dyn_address_valid_i (target_dyn_address_valid_i),
    .bus_start_det_i            (bus_start_det_i),
    .last_addr_o                (last_addr_o),
    .last_addr_valid_o          (last_addr_valid_o)
  );

  i3c_target_fsm u_target_fsm (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .bus_start_det_i       (bus_start_det_i),
    .bus_rstart_det_i      (bus_rstart_det_i),
    .bus_stop_det_i        (bus_stop_det_i),
    .bus_rx_req_byte_o     (bus_rx_req_byte_o),
    .bus_rx_req_bit_o      (bus_rx_req_bit_o),
    .bus_rx_done_i         (bus_rx_done_i),
    .bus_rx_data_i         (bus_rx_data_i),
    .bus_tx_req_byte_o     (bus_tx_req_byte_o),
    .bus_tx_req_bit_o      (bus_tx_req_bit_o),
    .bus_tx_req_value_o    (bus_tx_req_value_o),
    .bus_tx_done_i         (bus_tx_done_i),
    .tx_desc_avail_i       (tx_desc_avail_i),
    .addr                  (u_addr_if.fsm),
    .tx                    (u_tx_if.fsm),
    .rx_byte_done_o        (rx_byte_done),
    .rx_tbit_done_o        (rx_tbit_done),
    .target_idle_o         (target_idle_o),
    .target_transmitting_o (target_transmitting_o),
    .event_target_nack_o   (event_target_nack_o)
  );

  i3c_rx_datapath u_rx_datapath (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rx_byte_done_i    (rx_byte_done),
    .rx_tbit_done_i    (rx_tbit_done),
    .bus_rx_data_i     (bus_rx_data_i),
    .rx_fifo_wready_i  (rx_fifo_wready_i),
    .rx_fifo_wvalid_o  (rx_fifo_wvalid_o),
    .rx_fifo_wdata_o   (rx_fifo_wdata_o),
    .parity_err_o      (parity_err_o),
    .rx_overflow_err_o (rx_overflow_err_o)
  );

  i3c_tx_datapath u_tx_datapath (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .tx               (u_tx_if.datapath),
    .tx_fifo_rdata_i  (tx_fifo_rdata_i),
    .tx_last_byte_i   (tx_last_byte_i),
    .tx_fifo_rvalid_i (tx_fifo_rvalid_i),
    .tx_fifo_rready_o (tx_fifo_rready_o)
  );

endmodule

// File: bench/tb_i3c_target.sv
// ********************
// Testbench for the I3C target engine
// Bus model, transfer table, checks, timeout
// ********************
`timescale 1ns/1ns

module tb_i3c_target;
  localparam int NumEntries = 10;
  localparam int CycleLimit = 16 + 400 * NumEntries;

  typedef struct {
    logic [7:0]  addr;
    logic        bcast;
    logic [6:0]  sta;
    logic        sta_v;
    logic [6:0]  dyn;
    logic        dyn_v;
    int          n;
    logic [31:0] data;
    logic [3:0]  bad_tbit;
    logic        wready;
    logic        desc;
    logic        ack;
    int          exp_n;
    logic [31:0] exp_fifo;
    int          exp_perr;
    int          exp_ovf;
  } entry_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic bus_start_det_i, bus_rstart_det_i, bus_stop_det_i;
  logic bus_rx_done_i, bus_tx_done_i;
  logic [7:0] bus_rx_data_i, tx_fifo_rdata_i, bus_tx_req_value_o;
  logic [6:0] target_sta_address_i, target_dyn_address_i;
  logic target_sta_address_valid_i, target_dyn_address_valid_i;
  logic tx_desc_avail_i, tx_fifo_rvalid_i, tx_last_byte_i, rx_fifo_wready_i;
  logic bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o;
  logic tx_fifo_rready_o, rx_fifo_wvalid_o, target_idle_o, target_transmitting_o;
  logic event_target_nack_o, last_addr_valid_o, parity_err_o, rx_overflow_err_o;
  logic [7:0] rx_fifo_wdata_o, last_addr_o;

  entry_t     table_q [NumEntries];
  logic [7:0] got_q [$];
  int         perr_cnt;
  int         ovf_cnt;
  int         pop_cnt;
  int         nack_cnt;
  int         cycles = 0;
  integer     seed = 62318;

  i3c_target dut0 (.*);

  always #5 clk_i = ~clk_i;

  // FIFO writes, pops and event pulses, seen with pre-edge values
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (rx_fifo_wvalid_o && rx_fifo_wready_i) got_q.push_back(rx_fifo_wdata_o);
    if (parity_err_o) perr_cnt = perr_cnt + 1;
    if (rx_overflow_err_o) ovf_cnt = ovf_cnt + 1;
    if (tx_fifo_rready_o) pop_cnt = pop_cnt + 1;
    if (event_target_nack_o) nack_cnt = nack_cnt + 1;
  end

  always @(posedge clk_i) begin
    if (cycles >= CycleLimit) begin
      $display("sim failed");
      $fatal(1, "Timeout: the transfer table did not finish within %0d cycles", CycleLimit);
    end
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic pulse(ref logic sig);
    sig = 1'b1;
    @(negedge clk_i);
    sig = 1'b0;
  endtask

  task automatic random_wait();
    int d;
    d = ($unsigned($random(seed)) % 4) + 1;
    repeat (d - 1) @(negedge clk_i);
  endtask

  // Answers a byte or bit request from the target
  task automatic rx_answer(input logic is_bit, input logic [7:0] d);
    while (!(is_bit ? bus_rx_req_bit_o : bus_rx_req_byte_o)) @(negedge clk_i);
    random_wait();
    bus_rx_data_i = d;
    pulse(bus_rx_done_i);
  endtask

  task automatic tx_answer(input logic is_bit);
    while (!(is_bit ? bus_tx_req_bit_o : bus_tx_req_byte_o)) @(negedge clk_i);
    random_wait();
    pulse(bus_tx_done_i);
  endtask

  // Address byte, then ACK decision two cycles after its done strobe
  task automatic addr_phase(input logic [7:0] a, input logic ack);
    rx_answer(1'b0, a);
    check("event_target_nack_o", !ack, event_target_nack_o);
    @(negedge clk_i);
    check("bus_tx_req_bit_o", ack, bus_tx_req_bit_o);
    check("bus_tx_req_byte_o", 0, bus_tx_req_byte_o);
    check("target_transmitting_o", ack, target_transmitting_o);
    if (ack) begin
      check("bus_tx_req_value_o", 8'h00, bus_tx_req_value_o);
      tx_answer(1'b1);
    end
  endtask

  task automatic add(input int i, input logic [7:0] a, input logic bc, input logic [6:0] s,
                     input logic sv, input logic [6:0] dy, input logic dv, input int n,
                     input logic [31:0] d, input logic [3:0] bad, input logic wr,
                     input logic desc, input logic ack, input int en, input logic [31:0] ef,
                     input int ep, input int eo);
    table_q[i] = '{a, bc, s, sv, dy, dv, n, d, bad, wr, desc, ack, en, ef, ep, eo};
  endtask

  task automatic run_entry(input entry_t e);
    logic [7:0] b;
    got_q.delete();
    perr_cnt = 0;
    ovf_cnt = 0;
    pop_cnt = 0;
    nack_cnt = 0;
    target_sta_address_i = e.sta;
    target_sta_address_valid_i = e.sta_v;
    target_dyn_address_i = e.dyn;
    target_dyn_address_valid_i = e.dyn_v;
    rx_fifo_wready_i = e.wready;
    tx_desc_avail_i = e.desc;
    tx_fifo_rdata_i = e.data[7:0];
    tx_fifo_rvalid_i = 1'b1;
    tx_last_byte_i = (e.n == 1);
    pulse(bus_start_det_i);
    if (e.bcast) begin
      addr_phase(8'hFC, 1'b1);
      while (!bus_rx_req_byte_o) @(negedge clk_i);
      pulse(bus_rstart_det_i);
    end
    addr_phase(e.addr, e.ack);
    if (e.ack) begin
      check("last_addr_o", e.addr, last_addr_o);
      check("last_addr_valid_o", 1, last_addr_valid_o);
    end
    for (int i = 0; e.ack && i < e.n; i++) begin
      b = e.data[8*i +: 8];
      if (e.addr[0]) begin
        while (!bus_tx_req_byte_o) @(negedge clk_i);
        check("tx_fifo_rready_o", 1, tx_fifo_rready_o);
        check("bus_tx_req_value_o", b, bus_tx_req_value_o);
        tx_answer(1'b0);
        // Show-ahead head moves on after the pop
        tx_fifo_rdata_i = e.data[8*(i+1) +: 8];
        tx_last_byte_i = (i + 2 == e.n);
        tx_fifo_rvalid_i = (i + 1 < e.n);
        while (!bus_tx_req_bit_o) @(negedge clk_i);
        check("bus_tx_req_value_o", (i + 1 < e.n), bus_tx_req_value_o);
        tx_answer(1'b1);
      end else begin
        rx_answer(1'b0, b);
        rx_answer(1'b1, {7'b0, (~^b) ^ e.bad_tbit[i]});
      end
    end
    @(negedge clk_i);
    pulse(bus_stop_det_i);
    check("target_idle_o", 1, target_idle_o);
    rx_fifo_wready_i = 1'b1;
    while (rx_fifo_wvalid_o) @(negedge clk_i);
    @(negedge clk_i);
    check("rx fifo write count", e.exp_n, got_q.size());
    for (int i = 0; i < e.exp_n; i++) check("rx_fifo_wdata_o", e.exp_fifo[8*i +: 8], got_q[i]);
    check("parity_err_o pulses", e.exp_perr, perr_cnt);
    check("rx_overflow_err_o pulses", e.exp_ovf, ovf_cnt);
    // One pop per byte read
    check("tx_fifo_rready_o pulses", (e.ack && e.addr[0]) ? e.n : 0, pop_cnt);
    // Wait is entered on a NACK and at the end of a read
    check("event_target_nack_o pulses",
          (!e.ack || (e.addr[0] && e.n > 0)) ? 1 : 0, nack_cnt);
  endtask

  initial begin
    rst_ni = 1'b0;
    {bus_start_det_i, bus_rstart_det_i, bus_stop_det_i} = '0;
    {bus_rx_done_i, bus_tx_done_i, bus_rx_data_i, tx_fifo_rdata_i} = '0;
    {target_sta_address_i, target_dyn_address_i} = '0;
    {target_sta_address_valid_i, target_dyn_address_valid_i} = '0;
    {tx_desc_avail_i, tx_fifo_rvalid_i, tx_last_byte_i, rx_fifo_wready_i} = '0;
    // addr bc sta v dyn v n data bad wr desc ack exp_n exp_fifo perr ovf
    add(0, 8'h6A, 0, 7'h20, 1, 7'h35, 1, 3, 32'h00013CA5, 0, 1, 0, 1, 3, 32'h00013CA5, 0, 0);
    add(1, 8'h40, 0, 7'h20, 1, 7'h35, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0);
    add(2, 8'h40, 0, 7'h20, 1, 7'h35, 0, 1, 32'h77, 0, 1, 0, 1, 1, 32'h77, 0, 0);
    add(3, 8'h40, 0, 7'h20, 0, 7'h35, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0);
    add(4, 8'h6C, 0, 7'h20, 0, 7'h35, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0);
    add(5, 8'h6A, 0, 7'h20, 0, 7'h35, 1, 2, 32'h2211, 4'b0001, 1, 0, 1, 1, 32'h22, 1, 0);
    add(6, 8'h6A, 0, 7'h20, 0, 7'h35, 1, 2, 32'hC35A, 0, 0, 0, 1, 1, 32'h5A, 0, 1);
    add(7, 8'h6B, 0, 7'h20, 0, 7'h35, 1, 3, 32'h244281, 0, 1, 1, 1, 0, 0, 0, 0);
    add(8, 8'h6B, 0, 7'h20, 0, 7'h35, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0);
    add(9, 8'h6A, 1, 7'h20, 0, 7'h35, 1, 1, 32'h9E, 0, 1, 0, 1, 1, 32'h9E, 0, 0);
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check("target_idle_o", 1, target_idle_o);
    check("bus requests", 0, {bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o,
                              bus_tx_req_bit_o});
    check("reset outputs", 0, {tx_fifo_rready_o, rx_fifo_wvalid_o, last_addr_valid_o,
                               target_transmitting_o, event_target_nack_o, parity_err_o,
                               rx_overflow_err_o});
    for (int i = 0; i < NumEntries; i++) run_entry(table_q[i]);
    $display("sim passed");
    $finish;
  end

endmodule

// File: build.f
verilog/i3c_target_pkg.sv
verilog/i3c_target_if.sv
verilog/i3c_addr_decoder.sv
verilog/i3c_target_fsm.sv
verilog/i3c_rx_datapath.sv
verilog/i3c_tx_datapath.sv
verilog/i3c_target.sv
bench/tb_i3c_target.sv

// File: Makefile
TOP = tb_i3c_target

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --top-module $(TOP) -f build.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
